//--- common/stamofu_pkg.sv
/*
 * stamofu launch path shared definitions
 * field widths, vector types and the data cache bank select position
 */

`default_nettype none

package stamofu_pkg;

    // address widths
    localparam int VPN_WIDTH = 20;
    localparam int PO_WIDTH = 12;

    // completion queue tag
    localparam int LOG_STAMOFU_CQ_ENTRIES = 3;

    // launch queue depth
    localparam int STAMOFU_LQ_ENTRIES = 4;

    // word index bit that picks dcache bank 0 or 1
    localparam int DCACHE_WORD_ADDR_BANK_BIT = 0;

    typedef logic [VPN_WIDTH-1:0] vpn_t;
    typedef logic [PO_WIDTH-3:0] po_word_t;
    typedef logic [PO_WIDTH-4:0] bank_word_t;
    typedef logic [LOG_STAMOFU_CQ_ENTRIES-1:0] cq_index_t;
    typedef logic [3:0] mem_op_t;
    typedef logic [3:0] byte_mask_t;
    typedef logic [31:0] word_t;

    // is_store, is_amo, is_fence, is_mq, misaligned, misaligned_exception
    typedef logic [5:0] mem_flags_t;

    // packed queue entry, bank bit stored next to the word index
    localparam int LQ_DATA_WIDTH = 1 + 1 + 1
        + $bits(mem_op_t)
        + 1 + 1 + 1
        + $bits(vpn_t)
        + $bits(po_word_t)
        + 1
        + $bits(byte_mask_t)
        + $bits(word_t)
        + $bits(cq_index_t);

endpackage

`default_nettype wire

//--- verilog/q_fast_ready.sv
/*
 * q_fast_ready: circular FIFO with a registered enq_ready
 * ready is taken from the next occupancy, never from deq_ready
 */

`timescale 1ns/100ps
`default_nettype none

module q_fast_ready #(
    parameter int DATA_WIDTH = 32,
    parameter int NUM_ENTRIES = 4
) (
    input  wire logic                  CLK,
    input  wire logic                  rst_n,

    input  wire logic                  enq_valid,
    input  wire logic [DATA_WIDTH-1:0] enq_data,
    output logic                       enq_ready,

    output logic                       deq_valid,
    output logic [DATA_WIDTH-1:0]      deq_data,
    input  wire logic                  deq_ready
);

    localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam int CNT_W = $clog2(NUM_ENTRIES + 1);

    logic [DATA_WIDTH-1:0] entries [NUM_ENTRIES];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;

    logic enq_fire;
    logic deq_fire;

    assign enq_fire = enq_valid & enq_ready;
    assign deq_fire = deq_valid & deq_ready;

    // head entry read straight out of the array
    assign deq_valid = (count != '0);
    assign deq_data = entries[head];

    always_comb begin
        count_next = count;
        if (enq_fire & ~deq_fire) begin
            count_next = count + CNT_W'(1);
        end else if (deq_fire & ~enq_fire) begin
            count_next = count - CNT_W'(1);
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            enq_ready <= 1'b1;
        end else begin
            if (enq_fire) begin
                tail <= (tail == PTR_W'(NUM_ENTRIES - 1)) ? '0 : tail + PTR_W'(1);
            end
            if (deq_fire) begin
                head <= (head == PTR_W'(NUM_ENTRIES - 1)) ? '0 : head + PTR_W'(1);
            end
            count <= count_next;
            // short path: ready only looks at our own occupancy
            enq_ready <= (count_next != CNT_W'(NUM_ENTRIES));
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            entries[tail] <= enq_data;
        end
    end

endmodule

`default_nettype wire

//--- stamofu/stamofu_lq.sv
/*
 * stamofu launch queue
 * program-order buffer of issued requests, head steered to a dcache bank
 */

`timescale 1ns/100ps
`default_nettype none

module stamofu_lq (
    input  wire logic                  CLK,
    input  wire logic                  rst_n,

    // issue side
    input  wire logic                  enq_valid,
    input  wire logic                  is_store,
    input  wire logic                  is_amo,
    input  wire logic                  is_fence,
    input  stamofu_pkg::mem_op_t       op,
    input  wire logic                  is_mq,
    input  wire logic                  misaligned,
    input  wire logic                  misaligned_exception,
    input  stamofu_pkg::vpn_t          vpn,
    input  stamofu_pkg::po_word_t      po_word,
    input  stamofu_pkg::byte_mask_t    byte_mask,
    input  stamofu_pkg::word_t         write_data,
    input  stamofu_pkg::cq_index_t     cq_index,
    output logic                       enq_ack,

    // head entry towards the bank stages
    output logic                       deq_bank0_valid,
    output logic                       deq_bank1_valid,
    output logic                       deq_is_store,
    output logic                       deq_is_amo,
    output logic                       deq_is_fence,
    output stamofu_pkg::mem_op_t       deq_op,
    output logic                       deq_is_mq,
    output logic                       deq_misaligned,
    output logic                       deq_misaligned_exception,
    output stamofu_pkg::vpn_t          deq_vpn,
    output stamofu_pkg::po_word_t      deq_po_word,
    output stamofu_pkg::byte_mask_t    deq_byte_mask,
    output stamofu_pkg::word_t         deq_write_data,
    output stamofu_pkg::cq_index_t     deq_cq_index,
    input  wire logic                  deq_bank0_ack,
    input  wire logic                  deq_bank1_ack
);

    logic enq_bank;
    logic deq_valid;
    logic deq_bank;
    logic deq_ack;

    logic [stamofu_pkg::LQ_DATA_WIDTH-1:0] enq_entry;
    logic [stamofu_pkg::LQ_DATA_WIDTH-1:0] deq_entry;

    // bank picked once at enqueue and kept with the entry
    assign enq_bank = po_word[stamofu_pkg::DCACHE_WORD_ADDR_BANK_BIT];

    assign enq_entry = {is_store, is_amo, is_fence, op, is_mq, misaligned,
                        misaligned_exception, vpn, po_word, enq_bank, byte_mask,
                        write_data, cq_index};

    assign {deq_is_store, deq_is_amo, deq_is_fence, deq_op, deq_is_mq, deq_misaligned,
            deq_misaligned_exception, deq_vpn, deq_po_word, deq_bank, deq_byte_mask,
            deq_write_data, deq_cq_index} = deq_entry;

    assign deq_bank0_valid = deq_valid & ~deq_bank;
    assign deq_bank1_valid = deq_valid & deq_bank;

    // an empty stage acks on its own, so each ack counts only with its bank valid
    assign deq_ack = (deq_bank0_valid & deq_bank0_ack) | (deq_bank1_valid & deq_bank1_ack);

    q_fast_ready #(
        .DATA_WIDTH (stamofu_pkg::LQ_DATA_WIDTH),
        .NUM_ENTRIES(stamofu_pkg::STAMOFU_LQ_ENTRIES)
    ) u_req_q (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .enq_valid(enq_valid),
        .enq_data (enq_entry),
        .enq_ready(enq_ack),
        .deq_valid(deq_valid),
        .deq_data (deq_entry),
        .deq_ready(deq_ack)
    );

endmodule

`default_nettype wire

//--- stamofu/dcache_bank_req.sv
/*
 * dcache bank request stage
 * one-entry hold of a launched request, word index made bank-local
 */

`timescale 1ns/100ps
`default_nettype none

module dcache_bank_req (
    input  wire logic                  CLK,
    input  wire logic                  rst_n,

    // from launch queue
    input  wire logic                  lq_valid,
    input  stamofu_pkg::mem_op_t       lq_op,
    input  stamofu_pkg::mem_flags_t    lq_flags,
    input  stamofu_pkg::vpn_t          lq_vpn,
    input  stamofu_pkg::po_word_t      lq_po_word,
    input  stamofu_pkg::byte_mask_t    lq_byte_mask,
    input  stamofu_pkg::word_t         lq_write_data,
    input  stamofu_pkg::cq_index_t     lq_cq_index,
    output logic                       lq_ack,

    // to dcache bank
    output logic                       bank_valid,
    output stamofu_pkg::mem_op_t       bank_op,
    output stamofu_pkg::mem_flags_t    bank_flags,
    output stamofu_pkg::vpn_t          bank_vpn,
    output stamofu_pkg::bank_word_t    bank_word,
    output stamofu_pkg::byte_mask_t    bank_byte_mask,
    output stamofu_pkg::word_t         bank_write_data,
    output stamofu_pkg::cq_index_t     bank_cq_index,
    input  wire logic                  bank_ready
);

    logic load;

    // drop the bank select bit, keep the rest in order
    function automatic stamofu_pkg::bank_word_t strip_bank_bit(
        input stamofu_pkg::po_word_t word
    );
        stamofu_pkg::bank_word_t result;
        int j;
        result = '0;
        j = 0;
        for (int i = 0; i < $bits(stamofu_pkg::po_word_t); i++) begin
            if (i != stamofu_pkg::DCACHE_WORD_ADDR_BANK_BIT) begin
                result[j] = word[i];
                j++;
            end
        end
        return result;
    endfunction

    // free slot or the slot drains this cycle
    assign lq_ack = ~bank_valid | bank_ready;
    assign load = lq_valid & lq_ack;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            bank_valid <= 1'b0;
        end else if (load) begin
            bank_valid <= 1'b1;
        end else if (bank_ready) begin
            bank_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            bank_op <= lq_op;
            bank_flags <= lq_flags;
            bank_vpn <= lq_vpn;
            bank_word <= strip_bank_bit(lq_po_word);
            bank_byte_mask <= lq_byte_mask;
            bank_write_data <= lq_write_data;
            bank_cq_index <= lq_cq_index;
        end
    end

endmodule

`default_nettype wire

//--- verilog/stamofu_launch_top.sv
/*
 * stamofu launch path top
 * launch queue feeding one request stage per dcache bank
 */

`timescale 1ns/100ps
`default_nettype none

module stamofu_launch_top (
    input  wire logic                  CLK,
    input  wire logic                  rst_n,

    // issue side
    input  wire logic                  enq_valid,
    input  wire logic                  is_store,
    input  wire logic                  is_amo,
    input  wire logic                  is_fence,
    input  stamofu_pkg::mem_op_t       op,
    input  wire logic                  is_mq,
    input  wire logic                  misaligned,
    input  wire logic                  misaligned_exception,
    input  stamofu_pkg::vpn_t          vpn,
    input  stamofu_pkg::po_word_t      po_word,
    input  stamofu_pkg::byte_mask_t    byte_mask,
    input  stamofu_pkg::word_t         write_data,
    input  stamofu_pkg::cq_index_t     cq_index,
    output logic                       enq_ack,

    // bank 0
    output logic                       bank0_valid,
    output stamofu_pkg::mem_op_t       bank0_op,
    output stamofu_pkg::mem_flags_t    bank0_flags,
    output stamofu_pkg::vpn_t          bank0_vpn,
    output stamofu_pkg::bank_word_t    bank0_word,
    output stamofu_pkg::byte_mask_t    bank0_byte_mask,
    output stamofu_pkg::word_t         bank0_write_data,
    output stamofu_pkg::cq_index_t     bank0_cq_index,
    input  wire logic                  bank0_ready,

    // bank 1
    output logic                       bank1_valid,
    output stamofu_pkg::mem_op_t       bank1_op,
    output stamofu_pkg::mem_flags_t    bank1_flags,
    output stamofu_pkg::vpn_t          bank1_vpn,
    output stamofu_pkg::bank_word_t    bank1_word,
    output stamofu_pkg::byte_mask_t    bank1_byte_mask,
    output stamofu_pkg::word_t         bank1_write_data,
    output stamofu_pkg::cq_index_t     bank1_cq_index,
    input  wire logic                  bank1_ready
);

    logic deq_bank0_valid;
    logic deq_bank1_valid;
    logic deq_bank0_ack;
    logic deq_bank1_ack;

    logic deq_is_store;
    logic deq_is_amo;
    logic deq_is_fence;
    logic deq_is_mq;
    logic deq_misaligned;
    logic deq_misaligned_exception;

    stamofu_pkg::mem_op_t    deq_op;
    stamofu_pkg::vpn_t       deq_vpn;
    stamofu_pkg::po_word_t   deq_po_word;
    stamofu_pkg::byte_mask_t deq_byte_mask;
    stamofu_pkg::word_t      deq_write_data;
    stamofu_pkg::cq_index_t  deq_cq_index;
    stamofu_pkg::mem_flags_t deq_flags;

    // same head fields go to both banks, valids keep them apart
    assign deq_flags = {deq_is_store, deq_is_amo, deq_is_fence,
                        deq_is_mq, deq_misaligned, deq_misaligned_exception};

    stamofu_lq u_lq (
        .CLK(CLK), .rst_n(rst_n),
        .enq_valid(enq_valid), .is_store(is_store), .is_amo(is_amo),
        .is_fence(is_fence), .op(op), .is_mq(is_mq), .misaligned(misaligned),
        .misaligned_exception(misaligned_exception), .vpn(vpn), .po_word(po_word),
        .byte_mask(byte_mask), .write_data(write_data), .cq_index(cq_index),
        .enq_ack(enq_ack),
        .deq_bank0_valid(deq_bank0_valid), .deq_bank1_valid(deq_bank1_valid),
        .deq_is_store(deq_is_store), .deq_is_amo(deq_is_amo),
        .deq_is_fence(deq_is_fence), .deq_op(deq_op), .deq_is_mq(deq_is_mq),
        .deq_misaligned(deq_misaligned),
        .deq_misaligned_exception(deq_misaligned_exception),
        .deq_vpn(deq_vpn), .deq_po_word(deq_po_word), .deq_byte_mask(deq_byte_mask),
        .deq_write_data(deq_write_data), .deq_cq_index(deq_cq_index),
        .deq_bank0_ack(deq_bank0_ack), .deq_bank1_ack(deq_bank1_ack)
    );

    dcache_bank_req u_bank0 (
        .CLK(CLK), .rst_n(rst_n),
        .lq_valid(deq_bank0_valid), .lq_op(deq_op), .lq_flags(deq_flags),
        .lq_vpn(deq_vpn), .lq_po_word(deq_po_word), .lq_byte_mask(deq_byte_mask),
        .lq_write_data(deq_write_data), .lq_cq_index(deq_cq_index),
        .lq_ack(deq_bank0_ack),
        .bank_valid(bank0_valid), .bank_op(bank0_op), .bank_flags(bank0_flags),
        .bank_vpn(bank0_vpn), .bank_word(bank0_word),
        .bank_byte_mask(bank0_byte_mask), .bank_write_data(bank0_write_data),
        .bank_cq_index(bank0_cq_index), .bank_ready(bank0_ready)
    );

    dcache_bank_req u_bank1 (
        .CLK(CLK), .rst_n(rst_n),
        .lq_valid(deq_bank1_valid), .lq_op(deq_op), .lq_flags(deq_flags),
        .lq_vpn(deq_vpn), .lq_po_word(deq_po_word), .lq_byte_mask(deq_byte_mask),
        .lq_write_data(deq_write_data), .lq_cq_index(deq_cq_index),
        .lq_ack(deq_bank1_ack),
        .bank_valid(bank1_valid), .bank_op(bank1_op), .bank_flags(bank1_flags),
        .bank_vpn(bank1_vpn), .bank_word(bank1_word),
        .bank_byte_mask(bank1_byte_mask), .bank_write_data(bank1_write_data),
        .bank_cq_index(bank1_cq_index), .bank_ready(bank1_ready)
    );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
/*
 * testbench clock and reset
 * 20 ns clock, rst_n held low for the first 16 rising edges
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic CLK,
    output logic rst_n
);

    localparam int HALF_PERIOD = 10;
    localparam int RESET_CYCLES = 16;

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    // released just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/stamofu_launch_tb.sv
/*
 * stamofu launch path testbench
 * file-driven requests, per-bank scoreboards and a program-order check
 */

`timescale 1ns/100ps
`default_nettype none

module stamofu_launch_tb;

    localparam int MAX_REQS = 64;
    localparam int STALL_CYCLES = 10;
    localparam int HOLD_CYCLES = 16;
    localparam int BB = stamofu_pkg::DCACHE_WORD_ADDR_BANK_BIT;

    logic CLK, rst_n;
    logic enq_valid, is_store, is_amo, is_fence, is_mq, misaligned, misaligned_exception;
    logic enq_ack, bank0_valid, bank1_valid, bank0_ready, bank1_ready;
    stamofu_pkg::mem_op_t op, bank0_op, bank1_op;
    stamofu_pkg::vpn_t vpn, bank0_vpn, bank1_vpn;
    stamofu_pkg::po_word_t po_word;
    stamofu_pkg::bank_word_t bank0_word, bank1_word;
    stamofu_pkg::byte_mask_t byte_mask, bank0_byte_mask, bank1_byte_mask;
    stamofu_pkg::word_t write_data, bank0_write_data, bank1_write_data;
    stamofu_pkg::cq_index_t cq_index, bank0_cq_index, bank1_cq_index;
    stamofu_pkg::mem_flags_t bank0_flags, bank1_flags;

    // one entry per line of the input file
    stamofu_pkg::mem_flags_t v_flags [MAX_REQS];
    stamofu_pkg::mem_op_t v_op [MAX_REQS];
    stamofu_pkg::vpn_t v_vpn [MAX_REQS];
    stamofu_pkg::po_word_t v_po [MAX_REQS];
    stamofu_pkg::byte_mask_t v_mask [MAX_REQS];
    stamofu_pkg::word_t v_data [MAX_REQS];
    stamofu_pkg::cq_index_t v_cq [MAX_REQS];
    stamofu_pkg::bank_word_t v_bword [MAX_REQS];
    logic [3:0] v_mode [MAX_REQS];
    logic [15:0] v_rdy [MAX_REQS];

    int num_reqs, presented, value_errors, order_errors, other_errors;
    int sb0 [$];
    int sb1 [$];
    logic [1:0] shown;
    logic [7:0] mask0, mask1;
    logic [2:0] phase_cnt;
    logic loaded;

    tb_clk_gen u_clk_gen (.CLK(CLK), .rst_n(rst_n));

    stamofu_launch_top u_stamofu_launch_top (.*);

    task automatic check_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic load_vectors(output logic ok);
        int fd, n;
        string line;
        ok = 1'b0;
        num_reqs = 0;
        fd = $fopen("tests/stamofu_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_reqs < MAX_REQS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v_flags[num_reqs],
                                v_op[num_reqs], v_vpn[num_reqs], v_po[num_reqs],
                                v_mask[num_reqs], v_data[num_reqs], v_cq[num_reqs],
                                v_bword[num_reqs], v_mode[num_reqs], v_rdy[num_reqs]);
                    if (n == 10) begin
                        num_reqs++;
                    end
                end
            end
            $fclose(fd);
            ok = (num_reqs > 0);
        end
    endtask

    // bank readies step through the current 8-cycle patterns
    always @(posedge CLK) begin
        logic r0, r1;
        r0 = mask0[phase_cnt];
        r1 = mask1[phase_cnt];
        phase_cnt = phase_cnt + 3'd1;
        #2;
        bank0_ready = r0;
        bank1_ready = r1;
    end

    task automatic inspect_bank(input int b, input logic valid, input logic ready,
            input stamofu_pkg::mem_op_t b_op, input stamofu_pkg::mem_flags_t b_flags,
            input stamofu_pkg::vpn_t b_vpn, input stamofu_pkg::bank_word_t b_word,
            input stamofu_pkg::byte_mask_t b_mask, input stamofu_pkg::word_t b_data,
            input stamofu_pkg::cq_index_t b_cq);
        int depth, idx;
        string pfx;
        depth = (b == 0) ? sb0.size() : sb1.size();
        idx = (depth == 0) ? -1 : ((b == 0) ? sb0[0] : sb1[0]);
        pfx = $sformatf("bank%0d_", b);
        if (valid && !shown[b]) begin
            shown[b] = 1'b1;
            assert (depth != 0) else begin
                $display("%0t bank%0d presented a request that was never sent there", $time, b);
                other_errors++;
            end
            if (depth != 0) begin
                // stages are loaded one request per cycle in program order
                assert (idx == presented) else begin
                    $display("[FAIL] %0t %srequest_index expected %0d got %0d",
                             $time, pfx, presented, idx);
                    order_errors++;
                end
                presented = idx + 1;
                check_field({pfx, "op"}, 64'(v_op[idx]), 64'(b_op));
                check_field({pfx, "flags"}, 64'(v_flags[idx]), 64'(b_flags));
                check_field({pfx, "vpn"}, 64'(v_vpn[idx]), 64'(b_vpn));
                check_field({pfx, "word"}, 64'(v_bword[idx]), 64'(b_word));
                check_field({pfx, "byte_mask"}, 64'(v_mask[idx]), 64'(b_mask));
                check_field({pfx, "write_data"}, 64'(v_data[idx]), 64'(b_data));
                check_field({pfx, "cq_index"}, 64'(v_cq[idx]), 64'(b_cq));
            end
        end
        if (valid && ready) begin
            shown[b] = 1'b0;
            if (depth != 0 && b == 0) begin
                void'(sb0.pop_front());
            end else if (depth != 0) begin
                void'(sb1.pop_front());
            end
        end
    endtask

    always @(negedge CLK) begin
        if (rst_n) begin
            inspect_bank(0, bank0_valid, bank0_ready, bank0_op, bank0_flags, bank0_vpn,
                         bank0_word, bank0_byte_mask, bank0_write_data, bank0_cq_index);
            inspect_bank(1, bank1_valid, bank1_ready, bank1_op, bank1_flags, bank1_vpn,
                         bank1_word, bank1_byte_mask, bank1_write_data, bank1_cq_index);
        end
    end

    task automatic offer_request(input int i, input int max_wait, output logic accepted);
        int waited;
        {is_store, is_amo, is_fence, is_mq, misaligned, misaligned_exception} = v_flags[i];
        op = v_op[i];
        vpn = v_vpn[i];
        po_word = v_po[i];
        byte_mask = v_mask[i];
        write_data = v_data[i];
        cq_index = v_cq[i];
        enq_valid = 1'b1;
        accepted = 1'b0;
        waited = 0;
        while (!accepted && waited < max_wait) begin
            @(negedge CLK);
            if (enq_ack) begin
                accepted = 1'b1;
                if (v_po[i][BB]) begin
                    sb1.push_back(i);
                end else begin
                    sb0.push_back(i);
                end
            end
            @(posedge CLK);
            #2;
            waited++;
        end
        enq_valid = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        mask0 = 8'hff;
        mask1 = 8'hff;
        waited = 0;
        while ((sb0.size() != 0 || sb1.size() != 0) && waited < limit) begin
            @(posedge CLK);
            #2;
            waited++;
        end
    endtask

    task automatic run_full_phase(input int first, output int next);
        int last, expected, accepted_cnt, i;
        logic acc;
        last = first;
        while (last + 1 < num_reqs && v_mode[last + 1] == 4'd1) begin
            last++;
        end
        wait_drain(200);
        mask0 = 8'h00;
        mask1 = 8'h00;
        // first request fills its stage, a second one only if it targets the other bank
        expected = stamofu_pkg::STAMOFU_LQ_ENTRIES + 1;
        if (last > first && v_po[first][BB] != v_po[first + 1][BB]) begin
            expected++;
        end
        if (expected > last - first + 1) begin
            expected = last - first + 1;
        end
        accepted_cnt = 0;
        i = first;
        acc = 1'b1;
        while (i <= last && acc) begin
            offer_request(i, STALL_CYCLES, acc);
            if (acc) begin
                accepted_cnt++;
                i++;
            end
        end
        check_field("accepted_requests", 64'(expected), 64'(accepted_cnt));
        mask0 = 8'hff;
        mask1 = 8'hff;
        while (i <= last) begin
            offer_request(i, 1000000, acc);
            i++;
        end
        next = last + 1;
    endtask

    task automatic run_tests();
        int i, gap;
        logic acc;
        void'($urandom(32'hd18a));
        @(posedge rst_n);
        @(negedge CLK);
        check_field("enq_ack", 64'd1, 64'(enq_ack));
        check_field("bank0_valid", 64'd0, 64'(bank0_valid));
        check_field("bank1_valid", 64'd0, 64'(bank1_valid));
        @(posedge CLK);
        #2;
        i = 0;
        while (i < num_reqs) begin
            if (v_mode[i] == 4'd1) begin
                run_full_phase(i, i);
            end else begin
                mask0 = v_rdy[i][7:0];
                mask1 = v_rdy[i][15:8];
                gap = $urandom % 3;
                repeat (gap) begin
                    @(posedge CLK);
                    #2;
                end
                offer_request(i, 1000000, acc);
                // keep the stalled bank blocking the queue head for a while
                if (v_mode[i] == 4'd2) begin
                    repeat (HOLD_CYCLES) begin
                        @(posedge CLK);
                        #2;
                    end
                end
                i++;
            end
        end
        wait_drain(200);
        repeat (4) @(posedge CLK);
        assert (sb0.size() == 0 && sb1.size() == 0) else begin
            $display("requests never came out: %0d for bank0, %0d for bank1",
                     sb0.size(), sb1.size());
            other_errors++;
        end
        $display("errors: value %0d, order %0d, other %0d",
                 value_errors, order_errors, other_errors);
        if (value_errors + order_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        logic ok;
        enq_valid = 1'b0;
        {is_store, is_amo, is_fence, is_mq, misaligned, misaligned_exception} = 6'b0;
        op = '0;
        vpn = '0;
        po_word = '0;
        byte_mask = '0;
        write_data = '0;
        cq_index = '0;
        bank0_ready = 1'b0;
        bank1_ready = 1'b0;
        mask0 = 8'h00;
        mask1 = 8'h00;
        phase_cnt = 3'd0;
        shown = 2'b00;
        presented = 0;
        value_errors = 0;
        order_errors = 0;
        other_errors = 0;
        loaded = 1'b0;
        load_vectors(ok);
        loaded = 1'b1;
        if (!ok) begin
            $display("could not read any request from tests/stamofu_input.txt");
            $display("Testbench failed");
            $finish;
        end else begin
            run_tests();
        end
    end

    // watchdog scaled to the number of requests
    initial begin
        int limit;
        wait (loaded);
        limit = num_reqs * 40 + 200;
        repeat (limit) @(posedge CLK);
        $display("timeout after %0d cycles, requests stopped moving", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/stamofu_input.txt
# flags(st amo fen mq mis mex) op vpn po_word byte_mask write_data cq_index bank_word mode ready
# mode 0 stream, 1 both banks stalled until queue fills, 2 hold ready after accept; ready = b1,b0
20 1 12345 001 f deadbeef 0 000 0 a5c3
30 2 0abcd 002 3 01234567 1 001 0 3c96
08 0 fffff 0a5 1 89abcdef 2 052 0 5a0f
24 3 00001 1f0 c cafef00d 3 0f8 0 f0f0
22 4 54321 3ff 8 0badc0de 4 1ff 0 c3a5
23 5 1f2e3 17c 6 13572468 5 0be 0 9999
21 6 7a7a7 2d3 f a5a5a5a5 6 169 0 6e6e
3f 7 80000 048 2 5a5a5a5a 7 024 0 ffff
00 8 13579 133 4 fedcba98 0 099 0 1248
2a 9 2468a 2a6 9 76543210 1 153 0 8421
20 a 11111 0e1 f 11111111 2 070 0 00ff
20 b 22222 355 f 22222222 3 1aa 0 00ff
30 c 33333 0c8 3 33333333 4 064 0 00ff
20 d 44444 204 c 44444444 5 102 2 00ff
24 e 55555 0f7 1 55555555 6 07b 0 ffff
20 f 66666 1a2 f 66666666 7 0d1 0 9696
20 0 a0000 010 f a0a0a0a0 0 008 1 0000
20 1 a0001 011 f a1a1a1a1 1 008 1 0000
30 2 a0002 122 3 a2a2a2a2 2 091 1 0000
08 3 a0003 123 f a3a3a3a3 3 091 1 0000
20 4 a0004 2f4 8 a4a4a4a4 4 17a 1 0000
22 5 a0005 2f5 6 a5a5a5a5 5 17a 1 0000
20 6 a0006 386 f a6a6a6a6 6 1c3 1 0000
23 7 b0000 09b 2 b0b0b0b0 7 04d 0 c3a5
20 8 b0001 3e0 f b1b1b1b1 0 1f0 0 0ff0
3c 9 b0002 25d 5 b2b2b2b2 1 12e 0 a55a

//--- src.f
common/stamofu_pkg.sv
verilog/q_fast_ready.sv
stamofu/stamofu_lq.sv
stamofu/dcache_bank_req.sv
verilog/stamofu_launch_top.sv
tests/tb_clk_gen.sv
tests/stamofu_launch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the stamofu launch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module stamofu_launch_tb -o stamofu_sim > build.log 2>&1 \
    && ./obj_dir/stamofu_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
